/* design/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    // datapath width of the core
    parameter int xlen = 64;

    // execute unit opcodes
    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,
        op_srl   = 4'd6,
        op_sra   = 4'd7,
        op_slt   = 4'd8,   // signed compare
        op_sltu  = 4'd9,   // unsigned compare
        op_mul   = 4'd10,  // low half of product
        op_mulhu = 4'd11   // high half of unsigned product
    } alu_op_e;

    // true for the ops handled by the iterative multiplier
    function automatic logic is_mul_op(alu_op_e op);
        logic hit;
        case (op)
            op_mul,
            op_mulhu: hit = 1'b1;
            default:  hit = 1'b0;
        endcase
        return hit;
    endfunction

    // true for the three shift ops
    function automatic logic is_shift_op(alu_op_e op);
        logic hit;
        case (op)
            op_sll,
            op_srl,
            op_sra:  hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    // 12 codes used out of 16
    // codes 12 to 15 fall to the default paths and give zero

endpackage

`default_nettype wire

/* design/int_alu.sv */
`default_nettype none

module int_alu (
    input  exu_pkg::alu_op_e         op,
    input  logic                     word,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    output logic [exu_pkg::xlen-1:0] result
);

    localparam int w = exu_pkg::xlen;

    logic [w-1:0] src1_sx;    // low word sign extended
    logic [w-1:0] src1_zx;    // low word zero extended
    logic [w-1:0] src2_sx;
    logic [w-1:0] opa;
    logic [w-1:0] opb;
    logic [5:0]   shamt;
    logic [w-1:0] sum;
    logic [w-1:0] diff;
    logic         lt_s;
    logic         lt_u;
    logic [w-1:0] shift_res;
    logic [w-1:0] arith_res;

    assign src1_sx = {{(w-32){src1[31]}}, src1[31:0]};
    assign src1_zx = {{(w-32){1'b0}}, src1[31:0]};
    assign src2_sx = {{(w-32){src2[31]}}, src2[31:0]};

    // word ops work on the low halves
    // srlw must not shift sign bits in so it gets the zero extended word
    always_comb begin
        if (!word) begin
            opa = src1;
        end else if (op == exu_pkg::op_srl) begin
            opa = src1_zx;
        end else begin
            opa = src1_sx;
        end
    end

    assign opb   = word ? src2_sx : src2;
    assign shamt = word ? {1'b0, src2[4:0]} : src2[5:0];   // 5 bit amount for word ops

    assign sum  = opa + opb;
    assign diff = opa - opb;
    assign lt_s = $signed(opa) < $signed(opb);
    assign lt_u = opa < opb;

    always_comb begin
        case (op)
            exu_pkg::op_sll: shift_res = opa << shamt;
            exu_pkg::op_srl: shift_res = opa >> shamt;
            exu_pkg::op_sra: shift_res = $signed(opa) >>> shamt;
            default:         shift_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            exu_pkg::op_add:  arith_res = sum;
            exu_pkg::op_sub:  arith_res = diff;
            exu_pkg::op_and:  arith_res = opa & opb;
            exu_pkg::op_or:   arith_res = opa | opb;
            exu_pkg::op_xor:  arith_res = opa ^ opb;
            exu_pkg::op_slt:  arith_res = {{(w-1){1'b0}}, lt_s};
            exu_pkg::op_sltu: arith_res = {{(w-1){1'b0}}, lt_u};
            default:          arith_res = '0;
        endcase
    end

    // upper word of a word op is junk here
    // the result stage replaces it with the sign of bit 31
    always_comb begin
        if (exu_pkg::is_mul_op(op)) begin
            result = '0;             // product comes from the multiplier
        end else if (exu_pkg::is_shift_op(op)) begin
            result = shift_res;
        end else begin
            result = arith_res;
        end
    end

endmodule

`default_nettype wire

/* design/shift_add_mul.sv */
`default_nettype none

module shift_add_mul #(
    parameter int mul_bits_per_cycle = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  exu_pkg::alu_op_e         op,
    input  logic                     word,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    output logic                     busy,
    output logic                     mul_valid,
    input  logic                     mul_ready,
    output logic [exu_pkg::xlen-1:0] product,
    output logic                     word_flag
);

    localparam int w     = exu_pkg::xlen;
    localparam int steps = w / mul_bits_per_cycle;
    localparam int cnt_w = $clog2(steps) + 1;

    logic [2*w-1:0] mcand;       // multiplicand shifted up each step
    logic [w-1:0]   mplier;      // multiplier shifted down each step
    logic [2*w-1:0] acc;
    logic [2*w-1:0] partial;
    logic [cnt_w-1:0] count;
    logic           running;
    logic           want_high;
    logic           launch;

    assign launch = start && exu_pkg::is_mul_op(op);

    // sum of the partial products for the bits retired this cycle
    always_comb begin
        partial = '0;
        for (int i = 0; i < mul_bits_per_cycle; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            running   <= 1'b0;
            mul_valid <= 1'b0;
            count     <= '0;
        end else begin
            if (launch) begin
                busy    <= 1'b1;
                running <= 1'b1;
                count   <= cnt_w'(steps - 1);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == '0) begin   // last step done this edge
                    running   <= 1'b0;
                    mul_valid <= 1'b1;
                end
            end
            if (mul_valid && mul_ready) begin
                mul_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    // operands and accumulator
    always_ff @(posedge clk) begin
        if (launch) begin
            mcand     <= {{w{1'b0}}, (word ? {{(w-32){1'b0}}, src1[31:0]} : src1)};
            mplier    <= word ? {{(w-32){1'b0}}, src2[31:0]} : src2;
            acc       <= '0;
            want_high <= (op == exu_pkg::op_mulhu);
            word_flag <= word;
        end else if (running) begin
            acc    <= acc + partial;
            mcand  <= mcand << mul_bits_per_cycle;
            mplier <= mplier >> mul_bits_per_cycle;
        end
    end

    assign product = want_high ? acc[2*w-1:w] : acc[w-1:0];

endmodule

`default_nettype wire

/* design/exu_result_stage.sv */
`default_nettype none

module exu_result_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     in_is_mul,
    input  logic [exu_pkg::xlen-1:0] alu_result,
    input  logic                     alu_word,
    input  logic                     mul_busy,
    input  logic                     mul_valid,
    output logic                     mul_ready,
    input  logic [exu_pkg::xlen-1:0] mul_product,
    input  logic                     mul_word,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [exu_pkg::xlen-1:0] out_result
);

    localparam int w = exu_pkg::xlen;

    logic         out_free;
    logic         accept;
    logic         load_alu;
    logic         mul_fire;
    logic [w-1:0] sel_result;
    logic         sel_word;
    logic [w-1:0] ext_result;

    // register empty or being drained this cycle
    assign out_free = !out_valid || out_ready;

    assign in_ready  = !mul_busy && out_free;
    assign mul_ready = out_free;

    assign accept   = in_valid && in_ready;
    assign load_alu = accept && !in_is_mul;    // multiplies load later
    assign mul_fire = mul_valid && mul_ready;

    // in_ready is low while the multiplier is busy
    // so load_alu and mul_fire never coincide
    assign sel_result = mul_fire ? mul_product : alu_result;
    assign sel_word   = mul_fire ? mul_word : alu_word;

    assign ext_result = sel_word ? {{(w-32){sel_result[31]}}, sel_result[31:0]}
                                 : sel_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load_alu || mul_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_alu || mul_fire) begin
            out_result <= ext_result;
        end
    end

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`default_nettype none

module exec_unit #(
    parameter int mul_bits_per_cycle = 4    // 1 2 4 or 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  exu_pkg::alu_op_e         in_op,
    input  logic                     in_word,
    input  logic [exu_pkg::xlen-1:0] in_src1,
    input  logic [exu_pkg::xlen-1:0] in_src2,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [exu_pkg::xlen-1:0] out_result
);

    logic                     accept;
    logic                     in_is_mul;
    logic [exu_pkg::xlen-1:0] alu_result;
    logic                     mul_busy;
    logic                     mul_valid;
    logic                     mul_ready;
    logic [exu_pkg::xlen-1:0] mul_product;
    logic                     mul_word;

    assign accept    = in_valid && in_ready;
    assign in_is_mul = exu_pkg::is_mul_op(in_op);

    int_alu u_alu (
        .op     (in_op),
        .word   (in_word),
        .src1   (in_src1),
        .src2   (in_src2),
        .result (alu_result)
    );

    shift_add_mul #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) u_mul (
        .clk       (clk),
        .reset     (reset),
        .start     (accept),
        .op        (in_op),
        .word      (in_word),
        .src1      (in_src1),
        .src2      (in_src2),
        .busy      (mul_busy),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .product   (mul_product),
        .word_flag (mul_word)
    );

    exu_result_stage u_result (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_is_mul   (in_is_mul),
        .alu_result  (alu_result),
        .alu_word    (in_word),     // alu is combinational so the flag is the input's
        .mul_busy    (mul_busy),
        .mul_valid   (mul_valid),
        .mul_ready   (mul_ready),
        .mul_product (mul_product),
        .mul_word    (mul_word),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result)
    );

endmodule

`default_nettype wire

/* bench/exec_unit_props.sv */
`default_nettype none

module exec_unit_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     in_ready,
    input logic                     mul_busy,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [exu_pkg::xlen-1:0] out_result
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;   // count of failed assertions

    // nothing pending out of reset
    a_reset_clears_out: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            assert_fails++;
            $error("out_valid high in or right after reset");
        end

    // stalled result holds its value
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
            out_valid && !out_ready |=> out_valid && $stable(out_result))
        else begin
            assert_fails++;
            $error("out_result or out_valid changed while stalled");
        end

    a_busy_blocks_input: assert property (@(posedge clk) disable iff (reset)
            mul_busy |-> !in_ready)
        else begin
            assert_fails++;
            $error("in_ready high while the multiplier is busy");
        end

endmodule

bind exec_unit exec_unit_props u_props (
    .clk        (clk),
    .reset      (reset),
    .in_ready   (in_ready),
    .mul_busy   (mul_busy),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

`default_nettype wire

/* bench/exec_unit_tb.sv */
`default_nettype none

module exec_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mul_bpc         = 4;
    localparam int n_ops           = 1200;   // upper bound on operations over all tests
    localparam int watchdog_cycles = n_ops * (64 + 4) * 2 + 500;
    localparam int drain_cycles    = (64 + 4) * 4;   // outstanding results clear well before this

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    exu_pkg::alu_op_e         in_op;
    logic                     in_word;
    logic [exu_pkg::xlen-1:0] in_src1;
    logic [exu_pkg::xlen-1:0] in_src2;
    logic                     out_valid;
    logic                     out_ready;
    logic [exu_pkg::xlen-1:0] out_result;

    logic [exu_pkg::xlen-1:0] exp_q[$];      // expected results in issue order
    longint                   accept_cycle_q[$];
    longint                   cycle = 0;
    string                    test_name = "reset";
    bit                       check_latency = 1'b0;
    int                       ready_pct = 100;
    int                       n_checks = 0;
    int                       n_errors = 0;
    int                       n_tests = 0;
    int                       chk_start;
    int                       err_start;

    exec_unit #(
        .mul_bits_per_cycle (mul_bpc)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reference model straight from the opcode rules
    function automatic logic [63:0] expected_result(input exu_pkg::alu_op_e op,
            input logic word, input logic [63:0] a, input logic [63:0] b);
        logic [31:0]  a32;
        logic [31:0]  b32;
        logic [31:0]  r32;
        logic [127:0] prod;
        logic [63:0]  r;
        a32  = a[31:0];
        b32  = b[31:0];
        prod = {64'd0, a} * {64'd0, b};
        if (word) begin
            case (op)
                exu_pkg::op_add: r32 = a32 + b32;
                exu_pkg::op_sub: r32 = a32 - b32;
                exu_pkg::op_sll: r32 = a32 << b[4:0];
                exu_pkg::op_srl: r32 = a32 >> b[4:0];
                exu_pkg::op_sra: r32 = $signed(a32) >>> b[4:0];
                exu_pkg::op_mul: r32 = a32 * b32;
                default:         r32 = 32'd0;
            endcase
            r = {{32{r32[31]}}, r32};
        end else begin
            case (op)
                exu_pkg::op_add:   r = a + b;
                exu_pkg::op_sub:   r = a - b;
                exu_pkg::op_and:   r = a & b;
                exu_pkg::op_or:    r = a | b;
                exu_pkg::op_xor:   r = a ^ b;
                exu_pkg::op_sll:   r = a << b[5:0];
                exu_pkg::op_srl:   r = a >> b[5:0];
                exu_pkg::op_sra:   r = $signed(a) >>> b[5:0];
                exu_pkg::op_slt:   r = {63'd0, $signed(a) < $signed(b)};
                exu_pkg::op_sltu:  r = {63'd0, a < b};
                exu_pkg::op_mul:   r = prod[63:0];
                exu_pkg::op_mulhu: r = prod[127:64];
                default:           r = 64'd0;
            endcase
        end
        return r;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [63:0] edge_value(input int idx);
        case (idx)
            0:       return 64'h8000_0000_0000_0000;   // most negative
            1:       return '1;
            2:       return 64'd0;
            3:       return 64'd1;
            default: return rand64();
        endcase
    endfunction

    // ops that have a word form in this unit
    function automatic bit word_capable(input exu_pkg::alu_op_e op);
        case (op)
            exu_pkg::op_add, exu_pkg::op_sub, exu_pkg::op_sll,
            exu_pkg::op_srl, exu_pkg::op_sra, exu_pkg::op_mul: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // compare on output transfers then record new accepts
    always @(posedge clk) begin
        logic [63:0] exp;
        longint      acc_cycle;
        if (!reset) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: result transferred with no operation pending", test_name);
                    n_errors++;
                end else begin
                    exp       = exp_q.pop_front();
                    acc_cycle = accept_cycle_q.pop_front();
                    n_checks++;
                    if (out_result !== exp) begin
                        $display("mismatch %s: expected %h actual %h", test_name, exp,
                                 out_result);
                        n_errors++;
                    end
                    if (check_latency && (cycle - acc_cycle) != 1) begin
                        $display("mismatch %s latency: expected 1 actual %0d", test_name,
                                 cycle - acc_cycle);
                        n_errors++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_result(in_op, in_word, in_src1, in_src2));
                accept_cycle_q.push_back(cycle);
            end
        end
        cycle = cycle + 1;
    end

    // drawn on the edge and applied 1 ns later
    always begin
        bit next_ready;
        @(posedge clk);
        next_ready = ($urandom % 100) < ready_pct;
        #1;
        out_ready = next_ready;
    end

    task automatic issue(input exu_pkg::alu_op_e op, input logic word,
                         input logic [63:0] a, input logic [63:0] b);
        in_valid = 1'b1;
        in_op    = op;
        in_word  = word;
        in_src1  = a;
        in_src2  = b;
        do @(posedge clk); while (!in_ready);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic start_test(input string name, input bit latency, input int pct);
        test_name     = name;
        check_latency = latency;
        ready_pct     = pct;
        chk_start     = n_checks;
        err_start     = n_errors;
    endtask

    task automatic finish_test;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d results never came out", test_name, exp_q.size());
            n_errors++;
        end
        repeat (2) @(posedge clk);
        #1;
        n_tests++;
        $display("test %s done: %0d checks, %0d errors", test_name, n_checks - chk_start,
                 n_errors - err_start);
    endtask

    initial begin
        logic [63:0]      amt;
        exu_pkg::alu_op_e op;
        exu_pkg::alu_op_e shift_ops[3];
        exu_pkg::alu_op_e word_ops[5];
        void'($urandom(28));
        shift_ops = '{exu_pkg::op_sll, exu_pkg::op_srl, exu_pkg::op_sra};
        word_ops  = '{exu_pkg::op_add, exu_pkg::op_sub, exu_pkg::op_sll,
                      exu_pkg::op_srl, exu_pkg::op_sra};
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = exu_pkg::op_add;
        in_word   = 1'b0;
        in_src1   = '0;
        in_src2   = '0;
        out_ready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("alu_random", 1'b1, 100);
        for (int i = 0; i < 300; i++) begin
            op = exu_pkg::alu_op_e'(4'($urandom % 10));   // everything but the multiplies
            issue(op, 1'b0, rand64(), rand64());
        end
        finish_test();

        start_test("shift_compare", 1'b0, 100);
        for (int sh = 0; sh < 64; sh++) begin
            for (int k = 0; k < 3; k++) begin
                amt      = rand64();
                amt[5:0] = 6'(sh);
                issue(shift_ops[k], 1'b0, edge_value((sh + k) % 5), amt);
            end
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                issue(exu_pkg::op_slt, 1'b0, edge_value(i), edge_value(j));
                issue(exu_pkg::op_sltu, 1'b0, edge_value(i), edge_value(j));
            end
        end
        finish_test();

        start_test("word_mode", 1'b0, 100);
        for (int i = 0; i < 200; i++) begin
            issue(word_ops[$urandom % 5], 1'b1, rand64(), rand64());
        end
        finish_test();

        start_test("multiply", 1'b0, 100);
        for (int i = 0; i < 100; i++) begin
            op = ($urandom % 2) ? exu_pkg::op_mul : exu_pkg::op_mulhu;
            issue(op, (op == exu_pkg::op_mul) && ($urandom % 2), rand64(), rand64());
            issue(exu_pkg::alu_op_e'(4'($urandom % 10)), 1'b0, rand64(), rand64());
        end
        finish_test();

        start_test("backpressure", 1'b0, 50);
        for (int i = 0; i < 200; i++) begin
            op = exu_pkg::alu_op_e'(4'($urandom % 12));
            issue(op, word_capable(op) && ($urandom % 2), rand64(), rand64());
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d, left in queue %0d",
                 n_tests, n_checks, n_errors, i_dut.u_props.assert_fails, exp_q.size());
        if (n_errors == 0 && exp_q.size() == 0 && i_dut.u_props.assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s", watchdog_cycles, test_name);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/exu_pkg.sv
design/int_alu.sv
design/shift_add_mul.sv
design/exu_result_stage.sv
design/exec_unit.sv
bench/exec_unit_props.sv
bench/exec_unit_tb.sv
